/* logic/system_pkg.sv */
package system_pkg;

	typedef logic [15:0] io_addr_t;
	typedef logic [31:0] io_data_t;
	typedef logic [7:0]  io_byte_t;
	typedef logic [2:0]  io_size_t;
	typedef logic [21:0] io_sel_t;
	typedef logic [15:0] mgmt_addr_t;
	typedef logic [31:0] mgmt_data_t;

	typedef enum logic {
		SYS_BOOT,
		SYS_RUN
	} sysctl_state_t;

	localparam int unsigned SEL_HDD0       = 0;
	localparam int unsigned SEL_HDD1       = 1;
	localparam int unsigned SEL_FLOPPY     = 2;
	localparam int unsigned SEL_JOY        = 3;
	localparam int unsigned SEL_DMA_MASTER = 4;
	localparam int unsigned SEL_DMA_PAGE   = 5;
	localparam int unsigned SEL_DMA_SLAVE  = 6;
	localparam int unsigned SEL_PIC_MASTER = 7;
	localparam int unsigned SEL_PIC_SLAVE  = 8;
	localparam int unsigned SEL_PIT        = 9;
	localparam int unsigned SEL_PS2_IO     = 10;
	localparam int unsigned SEL_PS2_CTL    = 11;
	localparam int unsigned SEL_RTC        = 12;
	localparam int unsigned SEL_FM         = 13;
	localparam int unsigned SEL_SB         = 14;
	localparam int unsigned SEL_UART       = 15;
	localparam int unsigned SEL_MPU        = 16;
	localparam int unsigned SEL_VGA_B      = 17;
	localparam int unsigned SEL_VGA_C      = 18;
	localparam int unsigned SEL_VGA_D      = 19;
	localparam int unsigned SEL_SYSCTL     = 20;
	localparam int unsigned SEL_SPARE      = 21; // was the pci config select

	// base address, then number of ignored low address bits
	localparam io_addr_t    PORT_HDD0           = 16'h01F0;
	localparam int unsigned PORT_HDD0_IGN       = 3;
	localparam io_addr_t    PORT_HDD0_CTL       = 16'h03F6;
	localparam io_addr_t    PORT_HDD1           = 16'h0170;
	localparam int unsigned PORT_HDD1_IGN       = 3;
	localparam io_addr_t    PORT_HDD1_CTL       = 16'h0376;
	localparam io_addr_t    PORT_JOY            = 16'h0201;
	localparam int unsigned PORT_JOY_IGN        = 0;
	localparam io_addr_t    PORT_FLOPPY         = 16'h03F0;
	localparam int unsigned PORT_FLOPPY_IGN     = 3;
	localparam io_addr_t    PORT_DMA_MASTER     = 16'h00C0;
	localparam int unsigned PORT_DMA_MASTER_IGN = 5;
	localparam io_addr_t    PORT_DMA_PAGE       = 16'h0080;
	localparam int unsigned PORT_DMA_PAGE_IGN   = 4;
	localparam io_addr_t    PORT_DMA_SLAVE      = 16'h0000;
	localparam int unsigned PORT_DMA_SLAVE_IGN  = 4;
	localparam io_addr_t    PORT_PIC_MASTER     = 16'h0020;
	localparam int unsigned PORT_PIC_MASTER_IGN = 1;
	localparam io_addr_t    PORT_PIC_SLAVE      = 16'h00A0;
	localparam int unsigned PORT_PIC_SLAVE_IGN  = 1;
	localparam io_addr_t    PORT_PIT            = 16'h0040;
	localparam int unsigned PORT_PIT_IGN        = 2;
	localparam io_addr_t    PORT_PIT_SPK        = 16'h0061; // speaker gate, shared with ps2
	localparam io_addr_t    PORT_PS2_IO         = 16'h0060;
	localparam int unsigned PORT_PS2_IO_IGN     = 3;
	localparam io_addr_t    PORT_PS2_CTL        = 16'h0090;
	localparam int unsigned PORT_PS2_CTL_IGN    = 4;
	localparam io_addr_t    PORT_RTC            = 16'h0070;
	localparam int unsigned PORT_RTC_IGN        = 1;
	localparam io_addr_t    PORT_FM             = 16'h0388;
	localparam int unsigned PORT_FM_IGN         = 2;
	localparam io_addr_t    PORT_SB             = 16'h0220;
	localparam int unsigned PORT_SB_IGN         = 4;
	localparam io_addr_t    PORT_UART           = 16'h03F8;
	localparam int unsigned PORT_UART_IGN       = 3;
	localparam io_addr_t    PORT_MPU            = 16'h0330;
	localparam int unsigned PORT_MPU_IGN        = 1;
	localparam io_addr_t    PORT_VGA_B          = 16'h03B0;
	localparam int unsigned PORT_VGA_B_IGN      = 4;
	localparam io_addr_t    PORT_VGA_C          = 16'h03C0;
	localparam int unsigned PORT_VGA_C_IGN      = 4;
	localparam io_addr_t    PORT_VGA_D          = 16'h03D0;
	localparam int unsigned PORT_VGA_D_IGN      = 4;
	localparam io_addr_t    PORT_SYSCTL         = 16'h8888;
	localparam int unsigned PORT_SYSCTL_IGN     = 0;

	localparam io_byte_t    SYSCTL_KEY     = 8'hA1; // expected in writedata[15:8]
	localparam io_byte_t    SYSCFG_RESET   = 8'hA2;
	localparam io_size_t    IO_SIZE_WORD   = 3'd2;
	localparam int unsigned HDD_ALT_BIT    = 9; // set on the 3x6 control ports
	localparam io_byte_t    IO_IDLE_DATA   = 8'hFF;

	localparam logic [7:0]  MGMT_PAGE_HDD0 = 8'hF0;
	localparam logic [7:0]  MGMT_PAGE_HDD1 = 8'hF1;
	localparam logic [7:0]  MGMT_PAGE_FDD  = 8'hF2;
	localparam logic [7:0]  MGMT_PAGE_RTC  = 8'hF4;

	function automatic logic port_hit(input io_addr_t addr, input io_addr_t base,
			input int unsigned ign);
		io_addr_t mask;
		mask = ~io_addr_t'(0) << ign;
		return (addr & mask) == base;
	endfunction

endpackage

/* logic/io_port_decoder.sv */
module io_port_decoder (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  system_pkg::io_addr_t io_address,
	output system_pkg::io_sel_t  io_sel
);

	system_pkg::io_sel_t sel_next;

	always_comb begin
		sel_next = '0; // spare bit stays low
		sel_next[system_pkg::SEL_HDD0] =
			system_pkg::port_hit(io_address, system_pkg::PORT_HDD0, system_pkg::PORT_HDD0_IGN) ||
			(io_address == system_pkg::PORT_HDD0_CTL);
		sel_next[system_pkg::SEL_HDD1] =
			system_pkg::port_hit(io_address, system_pkg::PORT_HDD1, system_pkg::PORT_HDD1_IGN) ||
			(io_address == system_pkg::PORT_HDD1_CTL);
		sel_next[system_pkg::SEL_JOY] =
			system_pkg::port_hit(io_address, system_pkg::PORT_JOY, system_pkg::PORT_JOY_IGN);
		sel_next[system_pkg::SEL_FLOPPY] = system_pkg::port_hit(io_address,
			system_pkg::PORT_FLOPPY, system_pkg::PORT_FLOPPY_IGN);
		sel_next[system_pkg::SEL_DMA_MASTER] = system_pkg::port_hit(io_address,
			system_pkg::PORT_DMA_MASTER, system_pkg::PORT_DMA_MASTER_IGN);
		sel_next[system_pkg::SEL_DMA_PAGE] = system_pkg::port_hit(io_address,
			system_pkg::PORT_DMA_PAGE, system_pkg::PORT_DMA_PAGE_IGN);
		sel_next[system_pkg::SEL_DMA_SLAVE] = system_pkg::port_hit(io_address,
			system_pkg::PORT_DMA_SLAVE, system_pkg::PORT_DMA_SLAVE_IGN);
		sel_next[system_pkg::SEL_PIC_MASTER] = system_pkg::port_hit(io_address,
			system_pkg::PORT_PIC_MASTER, system_pkg::PORT_PIC_MASTER_IGN);
		sel_next[system_pkg::SEL_PIC_SLAVE] = system_pkg::port_hit(io_address,
			system_pkg::PORT_PIC_SLAVE, system_pkg::PORT_PIC_SLAVE_IGN);
		sel_next[system_pkg::SEL_PIT] =
			system_pkg::port_hit(io_address, system_pkg::PORT_PIT, system_pkg::PORT_PIT_IGN) ||
			(io_address == system_pkg::PORT_PIT_SPK); // 0061 also hits ps2_io
		sel_next[system_pkg::SEL_PS2_IO] = system_pkg::port_hit(io_address,
			system_pkg::PORT_PS2_IO, system_pkg::PORT_PS2_IO_IGN);
		sel_next[system_pkg::SEL_PS2_CTL] = system_pkg::port_hit(io_address,
			system_pkg::PORT_PS2_CTL, system_pkg::PORT_PS2_CTL_IGN);
		sel_next[system_pkg::SEL_RTC] =
			system_pkg::port_hit(io_address, system_pkg::PORT_RTC, system_pkg::PORT_RTC_IGN);
		sel_next[system_pkg::SEL_FM] =
			system_pkg::port_hit(io_address, system_pkg::PORT_FM, system_pkg::PORT_FM_IGN);
		sel_next[system_pkg::SEL_SB] =
			system_pkg::port_hit(io_address, system_pkg::PORT_SB, system_pkg::PORT_SB_IGN);
		sel_next[system_pkg::SEL_UART] =
			system_pkg::port_hit(io_address, system_pkg::PORT_UART, system_pkg::PORT_UART_IGN);
		sel_next[system_pkg::SEL_MPU] =
			system_pkg::port_hit(io_address, system_pkg::PORT_MPU, system_pkg::PORT_MPU_IGN);
		sel_next[system_pkg::SEL_VGA_B] = system_pkg::port_hit(io_address,
			system_pkg::PORT_VGA_B, system_pkg::PORT_VGA_B_IGN);
		sel_next[system_pkg::SEL_VGA_C] = system_pkg::port_hit(io_address,
			system_pkg::PORT_VGA_C, system_pkg::PORT_VGA_C_IGN);
		sel_next[system_pkg::SEL_VGA_D] = system_pkg::port_hit(io_address,
			system_pkg::PORT_VGA_D, system_pkg::PORT_VGA_D_IGN);
		sel_next[system_pkg::SEL_SYSCTL] = system_pkg::port_hit(io_address,
			system_pkg::PORT_SYSCTL, system_pkg::PORT_SYSCTL_IGN);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_sel <= '0;
		end else begin
			io_sel <= sel_next;
		end
	end

	// no pci device behind the spare select
	a_spare_low: assert property (@(posedge clk_sys) disable iff (reset)
		!io_sel[system_pkg::SEL_SPARE]);

endmodule

/* logic/sysctl_register.sv */
module sysctl_register (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  system_pkg::io_sel_t  io_sel,
	input  logic                 io_write,
	input  system_pkg::io_size_t io_datasize,
	input  system_pkg::io_data_t io_writedata,
	output system_pkg::io_byte_t syscfg
);

	system_pkg::sysctl_state_t state;
	logic                      disk_hit;
	logic                      boot_clear;
	logic                      key_write;

	assign disk_hit = io_sel[system_pkg::SEL_HDD0] | io_sel[system_pkg::SEL_HDD1] |
		io_sel[system_pkg::SEL_FLOPPY];

	assign boot_clear = (state == system_pkg::SYS_BOOT) && disk_hit; // first bios disk probe

	assign key_write = io_write && io_sel[system_pkg::SEL_SYSCTL] &&
		(io_datasize == system_pkg::IO_SIZE_WORD) &&
		(io_writedata[15:8] == system_pkg::SYSCTL_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= system_pkg::SYS_BOOT;
			syscfg <= system_pkg::SYSCFG_RESET;
		end else if (boot_clear) begin
			state  <= system_pkg::SYS_RUN;
			syscfg <= '0;
		end else if (key_write) begin
			state  <= system_pkg::SYS_RUN;
			syscfg <= io_writedata[7:0];
		end
	end

	a_cfg_cause: assert property (@(posedge clk_sys) disable iff (reset)
		(syscfg != $past(syscfg)) |-> $past(reset || boot_clear || key_write));

endmodule

/* logic/io_readback.sv */
module io_readback (
	input  system_pkg::io_sel_t  io_sel,
	input  system_pkg::io_addr_t io_address,
	input  system_pkg::io_data_t hdd0_readdata,
	input  system_pkg::io_data_t hdd1_readdata,
	input  system_pkg::io_byte_t floppy_readdata,
	input  system_pkg::io_byte_t dma_readdata,
	input  system_pkg::io_byte_t pic_readdata,
	input  system_pkg::io_byte_t pit_readdata,
	input  system_pkg::io_byte_t ps2_readdata,
	input  system_pkg::io_byte_t rtc_readdata,
	input  system_pkg::io_byte_t sound_readdata,
	input  system_pkg::io_byte_t uart_readdata,
	input  system_pkg::io_byte_t vga_readdata,
	input  system_pkg::io_byte_t joystick_readdata,
	output system_pkg::io_data_t io_readdata,
	output logic                 io_32bit
);

	system_pkg::io_byte_t rd8;
	logic                 disk_sel;

	always_comb begin
		if (io_sel[system_pkg::SEL_FLOPPY]) begin
			rd8 = floppy_readdata;
		end else if (io_sel[system_pkg::SEL_DMA_MASTER] | io_sel[system_pkg::SEL_DMA_SLAVE] |
				io_sel[system_pkg::SEL_DMA_PAGE]) begin
			rd8 = dma_readdata;
		end else if (io_sel[system_pkg::SEL_PIC_MASTER] | io_sel[system_pkg::SEL_PIC_SLAVE]) begin
			rd8 = pic_readdata;
		end else if (io_sel[system_pkg::SEL_PIT]) begin
			rd8 = pit_readdata; // wins over ps2 at 0061
		end else if (io_sel[system_pkg::SEL_PS2_IO] | io_sel[system_pkg::SEL_PS2_CTL]) begin
			rd8 = ps2_readdata;
		end else if (io_sel[system_pkg::SEL_RTC]) begin
			rd8 = rtc_readdata;
		end else if (io_sel[system_pkg::SEL_SB] | io_sel[system_pkg::SEL_FM]) begin
			rd8 = sound_readdata;
		end else if (io_sel[system_pkg::SEL_UART] | io_sel[system_pkg::SEL_MPU]) begin
			rd8 = uart_readdata;
		end else if (io_sel[system_pkg::SEL_VGA_B] | io_sel[system_pkg::SEL_VGA_C] |
				io_sel[system_pkg::SEL_VGA_D]) begin
			rd8 = vga_readdata;
		end else if (io_sel[system_pkg::SEL_JOY]) begin
			rd8 = joystick_readdata;
		end else begin
			rd8 = system_pkg::IO_IDLE_DATA; // open bus
		end
	end

	assign io_readdata = io_sel[system_pkg::SEL_HDD0] ? hdd0_readdata :
		io_sel[system_pkg::SEL_HDD1] ? hdd1_readdata : system_pkg::io_data_t'(rd8);

	assign disk_sel = io_sel[system_pkg::SEL_HDD0] | io_sel[system_pkg::SEL_HDD1];

	// data port is 32 bit wide, the control port at 3x6 is not
	assign io_32bit = (disk_sel & ~io_address[system_pkg::HDD_ALT_BIT]) |
		io_sel[system_pkg::SEL_SYSCTL];

endmodule

/* logic/mgmt_port_decoder.sv */
module mgmt_port_decoder (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  system_pkg::mgmt_addr_t mgmt_address,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  system_pkg::mgmt_data_t mgmt_hdd0_data,
	input  system_pkg::mgmt_data_t mgmt_hdd1_data,
	input  system_pkg::mgmt_data_t mgmt_fdd_data,
	output logic                   hdd0_mgmt_write,
	output logic                   hdd1_mgmt_write,
	output logic                   fdd_mgmt_write,
	output logic                   rtc_mgmt_write,
	output logic                   hdd0_mgmt_read,
	output logic                   hdd1_mgmt_read,
	output logic                   fdd_mgmt_read,
	output system_pkg::mgmt_data_t mgmt_readdata
);

	logic hdd0_cs;
	logic hdd1_cs;
	logic fdd_cs;
	logic rtc_cs;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdd0_cs <= 1'b0;
			hdd1_cs <= 1'b0;
			fdd_cs  <= 1'b0;
			rtc_cs  <= 1'b0;
		end else begin
			hdd0_cs <= (mgmt_address[15:8] == system_pkg::MGMT_PAGE_HDD0);
			hdd1_cs <= (mgmt_address[15:8] == system_pkg::MGMT_PAGE_HDD1);
			fdd_cs  <= (mgmt_address[15:8] == system_pkg::MGMT_PAGE_FDD);
			rtc_cs  <= (mgmt_address[15:8] == system_pkg::MGMT_PAGE_RTC);
		end
	end

	assign hdd0_mgmt_write = mgmt_write & hdd0_cs;
	assign hdd1_mgmt_write = mgmt_write & hdd1_cs;
	assign fdd_mgmt_write  = mgmt_write & fdd_cs;
	assign rtc_mgmt_write  = mgmt_write & rtc_cs; // rtc cmos is write only here
	assign hdd0_mgmt_read  = mgmt_read & hdd0_cs;
	assign hdd1_mgmt_read  = mgmt_read & hdd1_cs;
	assign fdd_mgmt_read   = mgmt_read & fdd_cs;

	assign mgmt_readdata = hdd0_cs ? mgmt_hdd0_data : hdd1_cs ? mgmt_hdd1_data : mgmt_fdd_data;

	a_one_write: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({hdd0_mgmt_write, hdd1_mgmt_write, fdd_mgmt_write, rtc_mgmt_write}));

endmodule

/* logic/system_glue.sv */
module system_glue (
	input  logic                   clk_sys,
	input  logic                   reset,

	input  system_pkg::io_addr_t   io_address,
	input  logic                   io_read,
	input  logic                   io_write,
	input  system_pkg::io_size_t   io_datasize,
	input  system_pkg::io_data_t   io_writedata,
	output system_pkg::io_data_t   io_readdata,
	output logic                   io_32bit,
	output system_pkg::io_sel_t    device_sel,
	output system_pkg::io_byte_t   syscfg,

	input  system_pkg::io_data_t   hdd0_readdata,
	input  system_pkg::io_data_t   hdd1_readdata,
	input  system_pkg::io_byte_t   floppy_readdata,
	input  system_pkg::io_byte_t   dma_readdata,
	input  system_pkg::io_byte_t   pic_readdata,
	input  system_pkg::io_byte_t   pit_readdata,
	input  system_pkg::io_byte_t   ps2_readdata,
	input  system_pkg::io_byte_t   rtc_readdata,
	input  system_pkg::io_byte_t   sound_readdata,
	input  system_pkg::io_byte_t   uart_readdata,
	input  system_pkg::io_byte_t   vga_readdata,
	input  system_pkg::io_byte_t   joystick_readdata,

	input  system_pkg::mgmt_addr_t mgmt_address,
	input  logic                   mgmt_read,
	input  logic                   mgmt_write,
	input  system_pkg::mgmt_data_t mgmt_hdd0_data,
	input  system_pkg::mgmt_data_t mgmt_hdd1_data,
	input  system_pkg::mgmt_data_t mgmt_fdd_data,
	output logic                   hdd0_mgmt_write,
	output logic                   hdd1_mgmt_write,
	output logic                   fdd_mgmt_write,
	output logic                   rtc_mgmt_write,
	output logic                   hdd0_mgmt_read,
	output logic                   hdd1_mgmt_read,
	output logic                   fdd_mgmt_read,
	output system_pkg::mgmt_data_t mgmt_readdata
);

	system_pkg::io_sel_t io_sel;

	assign device_sel = io_sel;

	io_port_decoder u_decoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_address (io_address),
		.io_sel     (io_sel)
	);

	sysctl_register u_sysctl (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_sel       (io_sel),
		.io_write     (io_write),
		.io_datasize  (io_datasize),
		.io_writedata (io_writedata),
		.syscfg       (syscfg)
	);

	io_readback u_readback (
		.io_sel            (io_sel),
		.io_address        (io_address),
		.hdd0_readdata     (hdd0_readdata),
		.hdd1_readdata     (hdd1_readdata),
		.floppy_readdata   (floppy_readdata),
		.dma_readdata      (dma_readdata),
		.pic_readdata      (pic_readdata),
		.pit_readdata      (pit_readdata),
		.ps2_readdata      (ps2_readdata),
		.rtc_readdata      (rtc_readdata),
		.sound_readdata    (sound_readdata),
		.uart_readdata     (uart_readdata),
		.vga_readdata      (vga_readdata),
		.joystick_readdata (joystick_readdata),
		.io_readdata       (io_readdata),
		.io_32bit          (io_32bit)
	);

	mgmt_port_decoder u_mgmt (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.mgmt_address    (mgmt_address),
		.mgmt_read       (mgmt_read),
		.mgmt_write      (mgmt_write),
		.mgmt_hdd0_data  (mgmt_hdd0_data),
		.mgmt_hdd1_data  (mgmt_hdd1_data),
		.mgmt_fdd_data   (mgmt_fdd_data),
		.hdd0_mgmt_write (hdd0_mgmt_write),
		.hdd1_mgmt_write (hdd1_mgmt_write),
		.fdd_mgmt_write  (fdd_mgmt_write),
		.rtc_mgmt_write  (rtc_mgmt_write),
		.hdd0_mgmt_read  (hdd0_mgmt_read),
		.hdd1_mgmt_read  (hdd1_mgmt_read),
		.fdd_mgmt_read   (fdd_mgmt_read),
		.mgmt_readdata   (mgmt_readdata)
	);

	// the cpu side never issues a read and a write in one cycle
	a_rw_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(io_read && io_write));

endmodule

/* testbench/tb_glue_model.svh */
`ifndef TB_GLUE_MODEL_SVH
`define TB_GLUE_MODEL_SVH

logic [31:0] lfsr_state = 32'h136b_819f;

// galois lfsr, one step per bit taken
function automatic logic [31:0] take_bits(input int unsigned n);
	logic [31:0] value;
	value = '0;
	for (int unsigned i = 0; i < n; i++) begin
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		value = {value[30:0], lfsr_state[0]};
	end
	return value;
endfunction

function automatic logic in_range(input system_pkg::io_addr_t addr,
		input system_pkg::io_addr_t base, input int unsigned ign);
	return (32'(addr) >= 32'(base)) && (32'(addr) < 32'(base) + (32'd1 << ign));
endfunction

// port map of a 486 pc, overlaps included
function automatic system_pkg::io_sel_t model_decode(input system_pkg::io_addr_t a);
	system_pkg::io_sel_t s;
	s = '0;
	s[system_pkg::SEL_HDD0]       = in_range(a, 16'h01F0, 3) || (a == 16'h03F6);
	s[system_pkg::SEL_HDD1]       = in_range(a, 16'h0170, 3) || (a == 16'h0376);
	s[system_pkg::SEL_FLOPPY]     = in_range(a, 16'h03F0, 3);
	s[system_pkg::SEL_JOY]        = (a == 16'h0201);
	s[system_pkg::SEL_DMA_MASTER] = in_range(a, 16'h00C0, 5);
	s[system_pkg::SEL_DMA_PAGE]   = in_range(a, 16'h0080, 4);
	s[system_pkg::SEL_DMA_SLAVE]  = in_range(a, 16'h0000, 4);
	s[system_pkg::SEL_PIC_MASTER] = in_range(a, 16'h0020, 1);
	s[system_pkg::SEL_PIC_SLAVE]  = in_range(a, 16'h00A0, 1);
	s[system_pkg::SEL_PIT]        = in_range(a, 16'h0040, 2) || (a == 16'h0061);
	s[system_pkg::SEL_PS2_IO]     = in_range(a, 16'h0060, 3);
	s[system_pkg::SEL_PS2_CTL]    = in_range(a, 16'h0090, 4);
	s[system_pkg::SEL_RTC]        = in_range(a, 16'h0070, 1);
	s[system_pkg::SEL_FM]         = in_range(a, 16'h0388, 2);
	s[system_pkg::SEL_SB]         = in_range(a, 16'h0220, 4);
	s[system_pkg::SEL_UART]       = in_range(a, 16'h03F8, 3);
	s[system_pkg::SEL_MPU]        = in_range(a, 16'h0330, 1);
	s[system_pkg::SEL_VGA_B]      = in_range(a, 16'h03B0, 4);
	s[system_pkg::SEL_VGA_C]      = in_range(a, 16'h03C0, 4);
	s[system_pkg::SEL_VGA_D]      = in_range(a, 16'h03D0, 4);
	s[system_pkg::SEL_SYSCTL]     = (a == 16'h8888);
	return s;
endfunction

function automatic system_pkg::io_data_t model_readdata(input system_pkg::io_sel_t s);
	if (s[system_pkg::SEL_HDD0]) return hdd0_readdata;
	if (s[system_pkg::SEL_HDD1]) return hdd1_readdata;
	if (s[system_pkg::SEL_FLOPPY]) return {24'h0, floppy_readdata};
	if (s[6:4] != 3'b000) return {24'h0, dma_readdata}; // master, page, slave
	if (s[8:7] != 2'b00) return {24'h0, pic_readdata};
	if (s[system_pkg::SEL_PIT]) return {24'h0, pit_readdata};
	if (s[11:10] != 2'b00) return {24'h0, ps2_readdata};
	if (s[system_pkg::SEL_RTC]) return {24'h0, rtc_readdata};
	if (s[14:13] != 2'b00) return {24'h0, sound_readdata};
	if (s[16:15] != 2'b00) return {24'h0, uart_readdata};
	if (s[19:17] != 3'b000) return {24'h0, vga_readdata};
	if (s[system_pkg::SEL_JOY]) return {24'h0, joystick_readdata};
	return 32'h0000_00FF;
endfunction

function automatic logic model_32bit(input system_pkg::io_sel_t s,
		input system_pkg::io_addr_t a);
	return ((s[system_pkg::SEL_HDD0] || s[system_pkg::SEL_HDD1]) && !a[9]) ||
		s[system_pkg::SEL_SYSCTL];
endfunction

// {hdd0, hdd1, fdd, rtc}
function automatic logic [3:0] model_page(input system_pkg::mgmt_addr_t m);
	return {m[15:8] == 8'hF0, m[15:8] == 8'hF1, m[15:8] == 8'hF2, m[15:8] == 8'hF4};
endfunction

task automatic check_sel(input string name, input system_pkg::io_sel_t got,
		input system_pkg::io_sel_t exp);
	if (got !== exp) fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_data(input string name, input system_pkg::io_data_t got,
		input system_pkg::io_data_t exp);
	if (got !== exp) fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_byte(input string name, input system_pkg::io_byte_t got,
		input system_pkg::io_byte_t exp);
	if (got !== exp) fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_mgmt(input string name, input system_pkg::mgmt_data_t got,
		input system_pkg::mgmt_data_t exp);
	if (got !== exp) fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_strobes(input logic [3:0] cs, input logic rd, input logic wr);
	check_bit("hdd0_mgmt_write", hdd0_mgmt_write, wr & cs[3]);
	check_bit("hdd1_mgmt_write", hdd1_mgmt_write, wr & cs[2]);
	check_bit("fdd_mgmt_write", fdd_mgmt_write, wr & cs[1]);
	check_bit("rtc_mgmt_write", rtc_mgmt_write, wr & cs[0]);
	check_bit("hdd0_mgmt_read", hdd0_mgmt_read, rd & cs[3]);
	check_bit("hdd1_mgmt_read", hdd1_mgmt_read, rd & cs[2]);
	check_bit("fdd_mgmt_read", fdd_mgmt_read, rd & cs[1]);
endtask

`endif

/* testbench/tb_system_glue.sv */
module tb_system_glue;

	localparam int unsigned NUM_RANDOM    = 2000;
	localparam int unsigned NUM_TXN       = NUM_RANDOM + 4;
	localparam int unsigned CLK_PERIOD    = 40;
	localparam int unsigned WATCHDOG_TIME = NUM_TXN * 4 * CLK_PERIOD + 200 * CLK_PERIOD;

	logic                   clk_sys = 1'b0;
	logic                   reset = 1'b1;
	system_pkg::io_addr_t   io_address = '0;
	logic                   io_read = 1'b0;
	logic                   io_write = 1'b0;
	system_pkg::io_size_t   io_datasize = '0;
	system_pkg::io_data_t   io_writedata = '0;
	system_pkg::io_data_t   io_readdata;
	logic                   io_32bit;
	system_pkg::io_sel_t    device_sel;
	system_pkg::io_byte_t   syscfg;
	system_pkg::io_data_t   hdd0_readdata = '0;
	system_pkg::io_data_t   hdd1_readdata = '0;
	system_pkg::io_byte_t   floppy_readdata = '0;
	system_pkg::io_byte_t   dma_readdata = '0;
	system_pkg::io_byte_t   pic_readdata = '0;
	system_pkg::io_byte_t   pit_readdata = '0;
	system_pkg::io_byte_t   ps2_readdata = '0;
	system_pkg::io_byte_t   rtc_readdata = '0;
	system_pkg::io_byte_t   sound_readdata = '0;
	system_pkg::io_byte_t   uart_readdata = '0;
	system_pkg::io_byte_t   vga_readdata = '0;
	system_pkg::io_byte_t   joystick_readdata = '0;
	system_pkg::mgmt_addr_t mgmt_address = '0;
	logic                   mgmt_read = 1'b0;
	logic                   mgmt_write = 1'b0;
	system_pkg::mgmt_data_t mgmt_hdd0_data = '0;
	system_pkg::mgmt_data_t mgmt_hdd1_data = '0;
	system_pkg::mgmt_data_t mgmt_fdd_data = '0;
	logic                   hdd0_mgmt_write;
	logic                   hdd1_mgmt_write;
	logic                   fdd_mgmt_write;
	logic                   rtc_mgmt_write;
	logic                   hdd0_mgmt_read;
	logic                   hdd1_mgmt_read;
	logic                   fdd_mgmt_read;
	system_pkg::mgmt_data_t mgmt_readdata;

	system_pkg::io_byte_t   exp_cfg = 8'hA2;
	logic                   cfg_boot = 1'b1;

	system_pkg::io_addr_t list_base [24] = '{
		16'h01F0, 16'h03F6, 16'h0170, 16'h0376, 16'h0201, 16'h03F0, 16'h00C0, 16'h0080,
		16'h0000, 16'h0020, 16'h00A0, 16'h0040, 16'h0061, 16'h0060, 16'h0090, 16'h0070,
		16'h0388, 16'h0220, 16'h03F8, 16'h0330, 16'h03B0, 16'h03C0, 16'h03D0, 16'h8888};
	int unsigned list_ign [24] = '{3, 0, 3, 0, 0, 3, 5, 4, 4, 1, 1, 2, 0, 3, 4, 1, 2, 4, 3, 1,
		4, 4, 4, 0};

	system_glue dut0 (.*);

	always #20 clk_sys = ~clk_sys;

	`include "tb_glue_model.svh"

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	function automatic system_pkg::io_addr_t random_address();
		int unsigned idx;
		system_pkg::io_addr_t low;
		if (take_bits(1) != 0) return system_pkg::io_addr_t'(take_bits(16));
		idx = take_bits(5) % 24;
		low = system_pkg::io_addr_t'(take_bits(5) & ((32'd1 << list_ign[idx]) - 1));
		return list_base[idx] | low;
	endfunction

	function automatic system_pkg::mgmt_addr_t random_mgmt_address();
		logic [7:0] page;
		case (take_bits(3))
			0: page = 8'hF0;
			1: page = 8'hF1;
			2: page = 8'hF2;
			3: page = 8'hF4;
			4: page = 8'hF3; // unused page
			default: page = 8'(take_bits(8));
		endcase
		return {page, 8'(take_bits(8))};
	endfunction

	task automatic drive_device_data();
		hdd0_readdata     <= take_bits(32);
		hdd1_readdata     <= take_bits(32);
		floppy_readdata   <= 8'(take_bits(8));
		dma_readdata      <= 8'(take_bits(8));
		pic_readdata      <= 8'(take_bits(8));
		pit_readdata      <= 8'(take_bits(8));
		ps2_readdata      <= 8'(take_bits(8));
		rtc_readdata      <= 8'(take_bits(8));
		sound_readdata    <= 8'(take_bits(8));
		uart_readdata     <= 8'(take_bits(8));
		vga_readdata      <= 8'(take_bits(8));
		joystick_readdata <= 8'(take_bits(8));
		mgmt_hdd0_data    <= take_bits(32);
		mgmt_hdd1_data    <= take_bits(32);
		mgmt_fdd_data     <= take_bits(32);
	endtask

	// address held two cycles, one strobe cycle, then idle
	task automatic run_txn(input system_pkg::io_addr_t addr, input system_pkg::mgmt_addr_t maddr,
			input logic wr, input logic rd, input system_pkg::io_size_t size,
			input system_pkg::io_data_t wdata, input logic mrd, input logic mwr);
		system_pkg::io_sel_t exp_sel;
		logic [3:0]          cs;
		@(posedge clk_sys);
		io_address   <= addr;
		mgmt_address <= maddr;
		drive_device_data();
		@(posedge clk_sys);
		@(negedge clk_sys);
		exp_sel = model_decode(addr);
		cs = model_page(maddr);
		check_sel("device_sel", device_sel, exp_sel);
		check_data("io_readdata", io_readdata, model_readdata(exp_sel));
		check_bit("io_32bit", io_32bit, model_32bit(exp_sel, addr));
		check_mgmt("mgmt_readdata", mgmt_readdata,
			cs[3] ? mgmt_hdd0_data : cs[2] ? mgmt_hdd1_data : mgmt_fdd_data);
		check_strobes(cs, 1'b0, 1'b0);
		if (cfg_boot && (exp_sel[2:0] != 3'b000)) begin
			cfg_boot = 1'b0; // first disk or floppy access
			exp_cfg  = 8'h00;
		end
		@(posedge clk_sys);
		io_write     <= wr;
		io_read      <= rd;
		io_datasize  <= size;
		io_writedata <= wdata;
		mgmt_read    <= mrd;
		mgmt_write   <= mwr;
		@(negedge clk_sys);
		check_byte("syscfg", syscfg, exp_cfg);
		check_strobes(cs, mrd, mwr);
		if (wr && exp_sel[system_pkg::SEL_SYSCTL] && (size == 3'd2) && (wdata[15:8] == 8'hA1)) begin
			cfg_boot = 1'b0;
			exp_cfg  = wdata[7:0];
		end
		@(posedge clk_sys);
		io_write   <= 1'b0;
		io_read    <= 1'b0;
		mgmt_read  <= 1'b0;
		mgmt_write <= 1'b0;
		@(negedge clk_sys);
		check_byte("syscfg", syscfg, exp_cfg);
	endtask

	task automatic random_txn();
		system_pkg::io_addr_t   addr;
		system_pkg::mgmt_addr_t maddr;
		system_pkg::io_size_t   size;
		system_pkg::io_data_t   wdata;
		logic                   wr;
		logic                   rd;
		logic                   mrd;
		logic                   mwr;
		addr  = random_address();
		maddr = random_mgmt_address();
		wr    = take_bits(1) != 0;
		rd    = !wr && (take_bits(1) != 0);
		size  = (take_bits(1) != 0) ? 3'd2 : 3'(take_bits(3));
		wdata = take_bits(32);
		if (take_bits(1) != 0) wdata[15:8] = 8'hA1; // right key half the time
		mrd   = take_bits(1) != 0;
		mwr   = take_bits(1) != 0;
		run_txn(addr, maddr, wr, rd, size, wdata, mrd, mwr);
	endtask

	initial begin
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_sel("device_sel", device_sel, '0);
		check_byte("syscfg", syscfg, 8'hA2);
		check_strobes(4'b0000, 1'b0, 1'b0);
		run_txn(16'h8888, 16'h0000, 1'b1, 1'b0, 3'd2, 32'h0000_5A33, 1'b0, 1'b0); // bad key
		run_txn(16'h8888, 16'h0000, 1'b1, 1'b0, 3'd4, 32'h0000_A133, 1'b0, 1'b0); // bad size
		run_txn(16'h01F0, 16'h0000, 1'b0, 1'b1, 3'd2, 32'h0, 1'b0, 1'b0);
		run_txn(16'h8888, 16'h0000, 1'b1, 1'b0, 3'd2, 32'h0000_A13C, 1'b0, 1'b0);
		for (int unsigned i = 0; i < NUM_RANDOM; i++) begin
			random_txn();
		end
		$display("Simulation finished: PASS");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		fail_run("timeout: the transaction sequence did not complete in the expected time");
	end

endmodule

/* sim.f */
+incdir+testbench
logic/system_pkg.sv
logic/io_port_decoder.sv
logic/sysctl_register.sv
logic/io_readback.sv
logic/mgmt_port_decoder.sv
logic/system_glue.sv
testbench/tb_system_glue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the glue testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module tb_system_glue -f sim.f -o tb_system_glue
./obj_dir/tb_system_glue 2>&1 | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "simulation ended without a result, see $LOG"
	exit 1
fi
